/* hdl/traffic_pkg.sv */
/*
 * Shared constants and types for the two-channel traffic controller.
 * The channel count is fixed at 2 because windows 2 and 3 of the address map
 * hold the channels. Register offsets come from address bits 2:0, and bits 11:3
 * are ignored, so offsets alias inside a window. A pkt_len of 0 sends
 * one-word packets.
 */
package traffic_pkg;

	// bus and stream widths
	localparam int NUM_CHANNELS = 2;
	localparam int DATA_W = 64;
	localparam int EMPTY_W = 3;
	localparam int RX_ERR_W = 6;
	localparam int MM_ADDR_W = 14;
	localparam int MM_DATA_W = 32;

	// windows carried in avl_mm_baddress[13:12]
	localparam logic [1:0] REGION_1588 = 2'd0;
	localparam logic [1:0] REGION_SELECT = 2'd1;
	localparam logic [1:0] REGION_CH0 = 2'd2;
	localparam logic [1:0] REGION_CH1 = 2'd3;

	// offsets inside a channel window
	localparam logic [2:0] REG_CFG = 3'd0;
	localparam logic [2:0] REG_STATUS = 3'd1;
	localparam logic [2:0] REG_TX_PKTS = 3'd2;
	localparam logic [2:0] REG_RX_PKTS = 3'd3;
	localparam logic [2:0] REG_RX_ERRS = 3'd4;
	localparam logic [2:0] REG_MISMATCH = 3'd5;
	localparam logic [2:0] REG_CLEAR = 3'd6;

	// path selector values
	localparam logic SEL_EXT = 1'b0;
	localparam logic SEL_LOCAL = 1'b1;

	// generator config word as seen on the bus and by the generator
	typedef union packed {
		logic [MM_DATA_W-1:0] raw;
		struct packed {
			logic [15:0] pkt_count;
			logic [7:0] pkt_len;
			logic [6:0] rsvd;
			logic start;
		} f;
	} gen_cfg_u;

endpackage

/* hdl/mm_address_decoder.sv */
/*
 * Register bus window decoder. Bits 13:12 pick one of four windows and
 * bits 2:0 give the offset. All slaves answer in the same cycle, so there
 * is no waitrequest. The 1588 window is decoded but always reads zero.
 */
`timescale 1ns/1ns

module mm_address_decoder import traffic_pkg::*;
(
	input logic avl_mm_read,
	input logic avl_mm_write,
	input logic [MM_ADDR_W-1:0] avl_mm_baddress,
	output logic sel_read,
	output logic sel_write,
	output logic [NUM_CHANNELS-1:0] ch_read,
	output logic [NUM_CHANNELS-1:0] ch_write,
	output logic [2:0] reg_offset,
	input logic [MM_DATA_W-1:0] sel_readdata,
	input logic [NUM_CHANNELS-1:0][MM_DATA_W-1:0] ch_readdata,
	output logic [MM_DATA_W-1:0] avl_mm_readdata
);

	logic [1:0] region;

	assign region = avl_mm_baddress[MM_ADDR_W-1 -: 2];
	assign reg_offset = avl_mm_baddress[2:0];

	// strobes reach only the addressed window
	assign sel_read = avl_mm_read & (region == REGION_SELECT);
	assign sel_write = avl_mm_write & (region == REGION_SELECT);
	assign ch_read[0] = avl_mm_read & (region == REGION_CH0);
	assign ch_write[0] = avl_mm_write & (region == REGION_CH0);
	assign ch_read[1] = avl_mm_read & (region == REGION_CH1);
	assign ch_write[1] = avl_mm_write & (region == REGION_CH1);

	// read data back from the addressed window
	always_comb
	begin
		case (region)
			REGION_SELECT: avl_mm_readdata = sel_readdata;
			REGION_CH0: avl_mm_readdata = ch_readdata[0];
			REGION_CH1: avl_mm_readdata = ch_readdata[1];
			default: avl_mm_readdata = '0;
		endcase
	end

endmodule

/* hdl/stream_select_csr.sv */
/*
 * Path selector register. Bit 0 of a write picks the stream source for
 * both channels, and the new path holds from the next cycle. Reset
 * selects the local generator and monitor.
 */
`timescale 1ns/1ns

module stream_select_csr import traffic_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic sel_read,
	input logic sel_write,
	input logic [MM_DATA_W-1:0] avl_mm_writedata,
	output logic [MM_DATA_W-1:0] sel_readdata,
	output logic path_sel
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			path_sel <= SEL_LOCAL;
		end
		else if (sel_write)
		begin
			path_sel <= avl_mm_writedata[0];
		end
	end

	// zero-extended readback
	assign sel_readdata = sel_read ? {{(MM_DATA_W-1){1'b0}}, path_sel} : '0;

endmodule

/* hdl/stream_path_mux.sv */
/*
 * Per-channel stream multiplexer and demultiplexer. The mux is purely
 * combinational and switches the moment path_sel changes, so switch only
 * between packets. The local source has no empty or error, and those
 * fields go out as zero on the local path.
 */
`timescale 1ns/1ns

module stream_path_mux import traffic_pkg::*;
(
	input logic path_sel,
	// local generator
	input logic [DATA_W-1:0] loc_tx_data,
	input logic loc_tx_sop,
	input logic loc_tx_eop,
	input logic loc_tx_val,
	output logic loc_tx_ready,
	// external transmit source
	input logic [DATA_W-1:0] ext_tx_data,
	input logic [EMPTY_W-1:0] ext_tx_empty,
	input logic ext_tx_sop,
	input logic ext_tx_eop,
	input logic ext_tx_error,
	input logic ext_tx_val,
	output logic ext_tx_ready,
	// MAC transmit
	output logic [DATA_W-1:0] avl_st_tx_data,
	output logic [EMPTY_W-1:0] avl_st_tx_empty,
	output logic avl_st_tx_sop,
	output logic avl_st_tx_eop,
	output logic avl_st_tx_error,
	output logic avl_st_tx_val,
	input logic avl_st_tx_ready,
	// MAC receive
	input logic [DATA_W-1:0] avl_st_rx_data,
	input logic [EMPTY_W-1:0] avl_st_rx_empty,
	input logic avl_st_rx_sop,
	input logic avl_st_rx_eop,
	input logic [RX_ERR_W-1:0] avl_st_rx_error,
	input logic avl_st_rx_val,
	output logic avl_st_rx_ready,
	// local monitor
	output logic [DATA_W-1:0] mon_rx_data,
	output logic mon_rx_sop,
	output logic mon_rx_eop,
	output logic [RX_ERR_W-1:0] mon_rx_error,
	output logic mon_rx_val,
	// external receive sink
	output logic [DATA_W-1:0] ext_rx_data,
	output logic [EMPTY_W-1:0] ext_rx_empty,
	output logic ext_rx_sop,
	output logic ext_rx_eop,
	output logic [RX_ERR_W-1:0] ext_rx_error,
	output logic ext_rx_val,
	input logic ext_rx_ready
);

	logic is_local;

	assign is_local = (path_sel == SEL_LOCAL);

	//////////////////////////////////////////////////////////////////////
	// transmit side

	assign avl_st_tx_data = is_local ? loc_tx_data : ext_tx_data;
	assign avl_st_tx_empty = is_local ? '0 : ext_tx_empty;
	assign avl_st_tx_sop = is_local ? loc_tx_sop : ext_tx_sop;
	assign avl_st_tx_eop = is_local ? loc_tx_eop : ext_tx_eop;
	assign avl_st_tx_error = is_local ? 1'b0 : ext_tx_error;
	assign avl_st_tx_val = is_local ? loc_tx_val : ext_tx_val;

	// unchosen source is held off
	assign loc_tx_ready = is_local & avl_st_tx_ready;
	assign ext_tx_ready = ~is_local & avl_st_tx_ready;

	//////////////////////////////////////////////////////////////////////
	// receive side

	assign mon_rx_data = avl_st_rx_data;
	assign mon_rx_sop = avl_st_rx_sop;
	assign mon_rx_eop = avl_st_rx_eop;
	assign mon_rx_error = avl_st_rx_error;
	assign mon_rx_val = is_local & avl_st_rx_val;

	assign ext_rx_data = avl_st_rx_data;
	assign ext_rx_empty = avl_st_rx_empty;
	assign ext_rx_sop = avl_st_rx_sop;
	assign ext_rx_eop = avl_st_rx_eop;
	assign ext_rx_error = avl_st_rx_error;
	assign ext_rx_val = ~is_local & avl_st_rx_val;

	// monitor never stalls
	assign avl_st_rx_ready = is_local ? 1'b1 : ext_rx_ready;

endmodule

/* hdl/channel_csr.sv */
/*
 * Per-channel register block for the generator and monitor. A REG_CFG
 * write is taken only while the generator is idle. Start also needs a
 * nonzero packet count. cfg_start and clear_counts are combinational
 * strobes in the write cycle, so they act at that cycle's clock edge.
 */
`timescale 1ns/1ns

module channel_csr import traffic_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic ch_read,
	input logic ch_write,
	input logic [2:0] reg_offset,
	input logic [MM_DATA_W-1:0] avl_mm_writedata,
	output logic [MM_DATA_W-1:0] ch_readdata,
	output logic cfg_start,
	output logic [15:0] cfg_pkt_count,
	output logic [7:0] cfg_pkt_len,
	output logic clear_counts,
	input logic busy,
	input logic [MM_DATA_W-1:0] tx_pkts,
	input logic [MM_DATA_W-1:0] rx_pkts,
	input logic [MM_DATA_W-1:0] rx_errs,
	input logic [MM_DATA_W-1:0] mismatches
);

	gen_cfg_u wr_cfg;
	gen_cfg_u cfg_q;
	logic cfg_wr;
	logic [MM_DATA_W-1:0] rd_mux;

	assign wr_cfg.raw = avl_mm_writedata;
	assign cfg_wr = ch_write & (reg_offset == REG_CFG) & ~busy;

	// config is frozen during a run
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cfg_q.raw <= '0;
		end
		else if (cfg_wr)
		begin
			cfg_q.raw <= wr_cfg.raw;
			cfg_q.f.start <= 1'b0;
		end
	end

	assign cfg_start = cfg_wr & wr_cfg.f.start & (wr_cfg.f.pkt_count != 16'd0);
	assign cfg_pkt_count = cfg_q.f.pkt_count;
	assign cfg_pkt_len = cfg_q.f.pkt_len;
	assign clear_counts = ch_write & (reg_offset == REG_CLEAR);

	always_comb
	begin
		case (reg_offset)
			REG_CFG: rd_mux = cfg_q.raw;
			REG_STATUS: rd_mux = {{(MM_DATA_W-1){1'b0}}, busy};
			REG_TX_PKTS: rd_mux = tx_pkts;
			REG_RX_PKTS: rd_mux = rx_pkts;
			REG_RX_ERRS: rd_mux = rx_errs;
			REG_MISMATCH: rd_mux = mismatches;
			default: rd_mux = '0;
		endcase
	end

	assign ch_readdata = ch_read ? rd_mux : '0;

endmodule

/* hdl/packet_generator.sv */
/*
 * Local packet generator. In packet p of a run, word w carries p in the
 * upper 32 bits and w in the lower 32 bits. The first sop word is
 * presented in the cycle after cfg_start. A word is held under
 * back-pressure. pkt_count and pkt_len must stay stable while busy.
 */
`timescale 1ns/1ns

module packet_generator import traffic_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cfg_start,
	input logic [15:0] cfg_pkt_count,
	input logic [7:0] cfg_pkt_len,
	input logic clear_counts,
	input logic tx_ready,
	output logic [DATA_W-1:0] tx_data,
	output logic tx_sop,
	output logic tx_eop,
	output logic tx_val,
	output logic busy,
	output logic [MM_DATA_W-1:0] tx_pkts
);

	logic [15:0] pkt_idx;
	logic [7:0] word_idx;
	logic [7:0] last_word;
	logic xfer;
	logic last_pkt;

	// length 0 behaves as 1
	assign last_word = (cfg_pkt_len == 8'd0) ? 8'd0 : cfg_pkt_len - 8'd1;
	assign last_pkt = (pkt_idx == cfg_pkt_count - 16'd1);
	assign xfer = tx_val & tx_ready;

	assign tx_data = {16'd0, pkt_idx, 24'd0, word_idx};
	assign tx_sop = (word_idx == 8'd0);
	assign tx_eop = (word_idx == last_word);
	assign busy = tx_val;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tx_val <= 1'b0;
			pkt_idx <= '0;
			word_idx <= '0;
		end
		else if (cfg_start)
		begin
			tx_val <= 1'b1;
			pkt_idx <= '0;
			word_idx <= '0;
		end
		else if (xfer)
		begin
			if (tx_eop)
			begin
				word_idx <= '0;
				if (last_pkt)
					tx_val <= 1'b0;
				else
					pkt_idx <= pkt_idx + 16'd1;
			end
			else
			begin
				word_idx <= word_idx + 8'd1;
			end
		end
	end

	// packets sent, kept across runs
	always_ff @(posedge clk)
	begin
		if (rst || clear_counts)
			tx_pkts <= '0;
		else if (xfer && tx_eop)
			tx_pkts <= tx_pkts + 1'b1;
	end

endmodule

/* hdl/packet_monitor.sv */
/*
 * Local packet monitor, always ready. It follows the expected packet and
 * word number by position and counts every accepted word that breaks the
 * packet rule. A packet counts as an error packet when any of its words
 * carries a nonzero rx_error. The expected packet number restarts at 0
 * only on clear or reset.
 */
`timescale 1ns/1ns

module packet_monitor import traffic_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic clear_counts,
	input logic [DATA_W-1:0] rx_data,
	input logic rx_sop,
	input logic rx_eop,
	input logic [RX_ERR_W-1:0] rx_error,
	input logic rx_val,
	output logic [MM_DATA_W-1:0] rx_pkts,
	output logic [MM_DATA_W-1:0] rx_errs,
	output logic [MM_DATA_W-1:0] mismatches,
	output logic mon_error
);

	logic [31:0] exp_pkt;
	logic [31:0] exp_word;
	logic pkt_err;
	logic word_bad;
	logic word_err;

	// data and sop position against the rule
	assign word_bad = (rx_data != {exp_pkt, exp_word}) || (rx_sop != (exp_word == 32'd0));
	assign word_err = |rx_error;
	assign mon_error = (mismatches != '0);

	always_ff @(posedge clk)
	begin
		if (rst || clear_counts)
		begin
			exp_pkt <= '0;
			exp_word <= '0;
			pkt_err <= 1'b0;
			rx_pkts <= '0;
			rx_errs <= '0;
			mismatches <= '0;
		end
		else if (rx_val)
		begin
			if (word_bad)
				mismatches <= mismatches + 1'b1;
			if (rx_eop)
			begin
				// packet counts land with eop
				exp_pkt <= exp_pkt + 32'd1;
				exp_word <= '0;
				pkt_err <= 1'b0;
				rx_pkts <= rx_pkts + 1'b1;
				if (pkt_err || word_err)
					rx_errs <= rx_errs + 1'b1;
			end
			else
			begin
				exp_word <= exp_word + 32'd1;
				pkt_err <= pkt_err | word_err;
			end
		end
	end

endmodule

/* hdl/traffic_controller_top.sv */
/*
 * Two-channel traffic controller top level. One selector steers both
 * channels between the local generator and monitor and the external
 * stream ports. The 1588 window exists on the bus and reads zero.
 */
`timescale 1ns/1ns

module traffic_controller_top import traffic_pkg::*;
(
	input logic clk,
	input logic rst,
	// register bus
	input logic avl_mm_read,
	input logic avl_mm_write,
	input logic [MM_ADDR_W-1:0] avl_mm_baddress,
	output logic [MM_DATA_W-1:0] avl_mm_readdata,
	input logic [MM_DATA_W-1:0] avl_mm_writedata,
	// MAC transmit
	output logic [NUM_CHANNELS-1:0][DATA_W-1:0] avl_st_tx_data,
	output logic [NUM_CHANNELS-1:0][EMPTY_W-1:0] avl_st_tx_empty,
	output logic [NUM_CHANNELS-1:0] avl_st_tx_sop,
	output logic [NUM_CHANNELS-1:0] avl_st_tx_eop,
	output logic [NUM_CHANNELS-1:0] avl_st_tx_error,
	output logic [NUM_CHANNELS-1:0] avl_st_tx_val,
	input logic [NUM_CHANNELS-1:0] avl_st_tx_ready,
	// MAC receive
	input logic [NUM_CHANNELS-1:0][DATA_W-1:0] avl_st_rx_data,
	input logic [NUM_CHANNELS-1:0][EMPTY_W-1:0] avl_st_rx_empty,
	input logic [NUM_CHANNELS-1:0] avl_st_rx_sop,
	input logic [NUM_CHANNELS-1:0] avl_st_rx_eop,
	input logic [NUM_CHANNELS-1:0][RX_ERR_W-1:0] avl_st_rx_error,
	input logic [NUM_CHANNELS-1:0] avl_st_rx_val,
	output logic [NUM_CHANNELS-1:0] avl_st_rx_ready,
	// external transmit source
	input logic [NUM_CHANNELS-1:0][DATA_W-1:0] ext_tx_data,
	input logic [NUM_CHANNELS-1:0][EMPTY_W-1:0] ext_tx_empty,
	input logic [NUM_CHANNELS-1:0] ext_tx_sop,
	input logic [NUM_CHANNELS-1:0] ext_tx_eop,
	input logic [NUM_CHANNELS-1:0] ext_tx_error,
	input logic [NUM_CHANNELS-1:0] ext_tx_val,
	output logic [NUM_CHANNELS-1:0] ext_tx_ready,
	// external receive sink
	output logic [NUM_CHANNELS-1:0][DATA_W-1:0] ext_rx_data,
	output logic [NUM_CHANNELS-1:0][EMPTY_W-1:0] ext_rx_empty,
	output logic [NUM_CHANNELS-1:0] ext_rx_sop,
	output logic [NUM_CHANNELS-1:0] ext_rx_eop,
	output logic [NUM_CHANNELS-1:0][RX_ERR_W-1:0] ext_rx_error,
	output logic [NUM_CHANNELS-1:0] ext_rx_val,
	input logic [NUM_CHANNELS-1:0] ext_rx_ready,
	output logic [NUM_CHANNELS-1:0] mon_error
);

	logic sel_read;
	logic sel_write;
	logic [NUM_CHANNELS-1:0] ch_read;
	logic [NUM_CHANNELS-1:0] ch_write;
	logic [2:0] reg_offset;
	logic [MM_DATA_W-1:0] sel_readdata;
	logic [NUM_CHANNELS-1:0][MM_DATA_W-1:0] ch_readdata;
	logic path_sel;

	mm_address_decoder u_decoder (
		.avl_mm_read(avl_mm_read),
		.avl_mm_write(avl_mm_write),
		.avl_mm_baddress(avl_mm_baddress),
		.sel_read(sel_read),
		.sel_write(sel_write),
		.ch_read(ch_read),
		.ch_write(ch_write),
		.reg_offset(reg_offset),
		.sel_readdata(sel_readdata),
		.ch_readdata(ch_readdata),
		.avl_mm_readdata(avl_mm_readdata)
	);

	stream_select_csr u_select (
		.clk(clk),
		.rst(rst),
		.sel_read(sel_read),
		.sel_write(sel_write),
		.avl_mm_writedata(avl_mm_writedata),
		.sel_readdata(sel_readdata),
		.path_sel(path_sel)
	);

	//////////////////////////////////////////////////////////////////////
	// per-channel generator, monitor and path mux

	for (genvar i = 0; i < NUM_CHANNELS; i++)
	begin : g_chan
		logic cfg_start;
		logic [15:0] cfg_pkt_count;
		logic [7:0] cfg_pkt_len;
		logic clear_counts;
		logic busy;
		logic [MM_DATA_W-1:0] tx_pkts;
		logic [MM_DATA_W-1:0] rx_pkts;
		logic [MM_DATA_W-1:0] rx_errs;
		logic [MM_DATA_W-1:0] mismatches;
		logic [DATA_W-1:0] gen_data;
		logic gen_sop;
		logic gen_eop;
		logic gen_val;
		logic gen_ready;
		logic [DATA_W-1:0] mon_data;
		logic mon_sop;
		logic mon_eop;
		logic [RX_ERR_W-1:0] mon_err;
		logic mon_val;

		channel_csr u_csr (
			.clk(clk),
			.rst(rst),
			.ch_read(ch_read[i]),
			.ch_write(ch_write[i]),
			.reg_offset(reg_offset),
			.avl_mm_writedata(avl_mm_writedata),
			.ch_readdata(ch_readdata[i]),
			.cfg_start(cfg_start),
			.cfg_pkt_count(cfg_pkt_count),
			.cfg_pkt_len(cfg_pkt_len),
			.clear_counts(clear_counts),
			.busy(busy),
			.tx_pkts(tx_pkts),
			.rx_pkts(rx_pkts),
			.rx_errs(rx_errs),
			.mismatches(mismatches)
		);

		packet_generator u_gen (
			.clk(clk),
			.rst(rst),
			.cfg_start(cfg_start),
			.cfg_pkt_count(cfg_pkt_count),
			.cfg_pkt_len(cfg_pkt_len),
			.clear_counts(clear_counts),
			.tx_ready(gen_ready),
			.tx_data(gen_data),
			.tx_sop(gen_sop),
			.tx_eop(gen_eop),
			.tx_val(gen_val),
			.busy(busy),
			.tx_pkts(tx_pkts)
		);

		packet_monitor u_mon (
			.clk(clk),
			.rst(rst),
			.clear_counts(clear_counts),
			.rx_data(mon_data),
			.rx_sop(mon_sop),
			.rx_eop(mon_eop),
			.rx_error(mon_err),
			.rx_val(mon_val),
			.rx_pkts(rx_pkts),
			.rx_errs(rx_errs),
			.mismatches(mismatches),
			.mon_error(mon_error[i])
		);

		stream_path_mux u_mux (
			.path_sel(path_sel),
			.loc_tx_data(gen_data),
			.loc_tx_sop(gen_sop),
			.loc_tx_eop(gen_eop),
			.loc_tx_val(gen_val),
			.loc_tx_ready(gen_ready),
			.ext_tx_data(ext_tx_data[i]),
			.ext_tx_empty(ext_tx_empty[i]),
			.ext_tx_sop(ext_tx_sop[i]),
			.ext_tx_eop(ext_tx_eop[i]),
			.ext_tx_error(ext_tx_error[i]),
			.ext_tx_val(ext_tx_val[i]),
			.ext_tx_ready(ext_tx_ready[i]),
			.avl_st_tx_data(avl_st_tx_data[i]),
			.avl_st_tx_empty(avl_st_tx_empty[i]),
			.avl_st_tx_sop(avl_st_tx_sop[i]),
			.avl_st_tx_eop(avl_st_tx_eop[i]),
			.avl_st_tx_error(avl_st_tx_error[i]),
			.avl_st_tx_val(avl_st_tx_val[i]),
			.avl_st_tx_ready(avl_st_tx_ready[i]),
			.avl_st_rx_data(avl_st_rx_data[i]),
			.avl_st_rx_empty(avl_st_rx_empty[i]),
			.avl_st_rx_sop(avl_st_rx_sop[i]),
			.avl_st_rx_eop(avl_st_rx_eop[i]),
			.avl_st_rx_error(avl_st_rx_error[i]),
			.avl_st_rx_val(avl_st_rx_val[i]),
			.avl_st_rx_ready(avl_st_rx_ready[i]),
			.mon_rx_data(mon_data),
			.mon_rx_sop(mon_sop),
			.mon_rx_eop(mon_eop),
			.mon_rx_error(mon_err),
			.mon_rx_val(mon_val),
			.ext_rx_data(ext_rx_data[i]),
			.ext_rx_empty(ext_rx_empty[i]),
			.ext_rx_sop(ext_rx_sop[i]),
			.ext_rx_eop(ext_rx_eop[i]),
			.ext_rx_error(ext_rx_error[i]),
			.ext_rx_val(ext_rx_val[i]),
			.ext_rx_ready(ext_rx_ready[i])
		);
	end

endmodule

/* testbench/traffic_controller_tb.sv */
/*
 * Testbench for the two-channel traffic controller.
 * Runs the command lines of testbench/traffic_patterns.txt, so it must be
 * started from the project root. All pattern fields are hex.
 * ext_rx_ready toggles at random while receive words go to the external
 * path, and is held high otherwise.
 * The watchdog limit is 4 cycles per packet word in the file plus 200.
 */
`timescale 1ns/1ns

module traffic_controller_tb import traffic_pkg::*;
();

	logic clk;
	logic rst;
	logic avl_mm_read;
	logic avl_mm_write;
	logic [MM_ADDR_W-1:0] avl_mm_baddress;
	logic [MM_DATA_W-1:0] avl_mm_readdata;
	logic [MM_DATA_W-1:0] avl_mm_writedata;
	logic [NUM_CHANNELS-1:0][DATA_W-1:0] avl_st_tx_data;
	logic [NUM_CHANNELS-1:0][EMPTY_W-1:0] avl_st_tx_empty;
	logic [NUM_CHANNELS-1:0] avl_st_tx_sop;
	logic [NUM_CHANNELS-1:0] avl_st_tx_eop;
	logic [NUM_CHANNELS-1:0] avl_st_tx_error;
	logic [NUM_CHANNELS-1:0] avl_st_tx_val;
	logic [NUM_CHANNELS-1:0] avl_st_tx_ready;
	logic [NUM_CHANNELS-1:0][DATA_W-1:0] avl_st_rx_data;
	logic [NUM_CHANNELS-1:0][EMPTY_W-1:0] avl_st_rx_empty;
	logic [NUM_CHANNELS-1:0] avl_st_rx_sop;
	logic [NUM_CHANNELS-1:0] avl_st_rx_eop;
	logic [NUM_CHANNELS-1:0][RX_ERR_W-1:0] avl_st_rx_error;
	logic [NUM_CHANNELS-1:0] avl_st_rx_val;
	logic [NUM_CHANNELS-1:0] avl_st_rx_ready;
	logic [NUM_CHANNELS-1:0][DATA_W-1:0] ext_tx_data;
	logic [NUM_CHANNELS-1:0][EMPTY_W-1:0] ext_tx_empty;
	logic [NUM_CHANNELS-1:0] ext_tx_sop;
	logic [NUM_CHANNELS-1:0] ext_tx_eop;
	logic [NUM_CHANNELS-1:0] ext_tx_error;
	logic [NUM_CHANNELS-1:0] ext_tx_val;
	logic [NUM_CHANNELS-1:0] ext_tx_ready;
	logic [NUM_CHANNELS-1:0][DATA_W-1:0] ext_rx_data;
	logic [NUM_CHANNELS-1:0][EMPTY_W-1:0] ext_rx_empty;
	logic [NUM_CHANNELS-1:0] ext_rx_sop;
	logic [NUM_CHANNELS-1:0] ext_rx_eop;
	logic [NUM_CHANNELS-1:0][RX_ERR_W-1:0] ext_rx_error;
	logic [NUM_CHANNELS-1:0] ext_rx_val;
	logic [NUM_CHANNELS-1:0] ext_rx_ready;
	logic [NUM_CHANNELS-1:0] mon_error;

	integer seed = 25011;
	int mismatch_errs = 0;
	int other_errs = 0;
	int watch_cycles = 0;
	int pat_fd;
	int pat_words;
	// model of the next expected rx packet number and of the mismatch count
	int rx_next [NUM_CHANNELS];
	int mism_model [NUM_CHANNELS];
	logic path_local;

	traffic_controller_top uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks

	task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			mismatch_errs++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input logic [MM_DATA_W-1:0] got, input logic [MM_DATA_W-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			mismatch_errs++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			mismatch_errs++;
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// register bus

	task automatic bus_write(input logic [MM_ADDR_W-1:0] addr, input logic [MM_DATA_W-1:0] data);
		@(negedge clk);
		avl_mm_write = 1'b1;
		avl_mm_baddress = addr;
		avl_mm_writedata = data;
		@(negedge clk);
		avl_mm_write = 1'b0;
	endtask

	task automatic bus_read(input logic [MM_ADDR_W-1:0] addr, input logic [MM_DATA_W-1:0] exp);
		@(negedge clk);
		avl_mm_read = 1'b1;
		avl_mm_baddress = addr;
		// read data settles well before the next rising edge
		#10;
		check_reg(avl_mm_readdata, exp, $sformatf("read of %h", addr));
		@(negedge clk);
		avl_mm_read = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stream models

	// transmit sink with random back-pressure, checks the packet rule
	task automatic expect_tx(input int ch, input int count, input int len);
		int eff_len;
		int p;
		int w;
		eff_len = (len == 0) ? 1 : len;
		p = 0;
		w = 0;
		while (p < count)
		begin
			@(negedge clk);
			avl_st_tx_ready[ch] = ($random(seed) % 4) != 0;
			if (avl_st_tx_val[ch] && avl_st_tx_ready[ch])
			begin
				check_word(avl_st_tx_data[ch], {32'(p), 32'(w)}, "tx data");
				check_flag(avl_st_tx_sop[ch], w == 0, "tx sop");
				check_flag(avl_st_tx_eop[ch], w == eff_len - 1, "tx eop");
				check_flag(avl_st_tx_error[ch], 1'b0, "tx error");
				check_flag(|avl_st_tx_empty[ch], 1'b0, "tx empty");
				if (w == eff_len - 1)
				begin
					w = 0;
					p++;
				end
				else
					w++;
			end
		end
		@(negedge clk);
		avl_st_tx_ready[ch] = 1'b0;
		check_flag(avl_st_tx_val[ch], 1'b0, "tx val after last packet");
	endtask

	// one-word packet from the external source
	// empty and error come from the low bits of the word
	task automatic send_ext_tx(input int ch, input logic [DATA_W-1:0] value);
		logic done;
		done = 1'b0;
		@(negedge clk);
		ext_tx_data[ch] = value;
		ext_tx_empty[ch] = value[EMPTY_W-1:0];
		ext_tx_error[ch] = value[EMPTY_W];
		ext_tx_sop[ch] = 1'b1;
		ext_tx_eop[ch] = 1'b1;
		ext_tx_val[ch] = 1'b1;
		while (!done)
		begin
			avl_st_tx_ready[ch] = ($random(seed) % 4) != 0;
			#10;
			check_flag(avl_st_tx_val[ch], 1'b1, "ext tx val");
			check_word(avl_st_tx_data[ch], value, "ext tx data");
			check_word(DATA_W'(avl_st_tx_empty[ch]), DATA_W'(value[EMPTY_W-1:0]),
				"ext tx empty");
			check_flag(avl_st_tx_error[ch], value[EMPTY_W], "ext tx error");
			check_flag(avl_st_tx_sop[ch] & avl_st_tx_eop[ch], 1'b1, "ext tx sop and eop");
			check_flag(ext_tx_ready[ch], avl_st_tx_ready[ch], "ext tx ready");
			done = ext_tx_ready[ch];
			@(negedge clk);
		end
		ext_tx_val[ch] = 1'b0;
		ext_tx_empty[ch] = '0;
		ext_tx_error[ch] = 1'b0;
		avl_st_tx_ready[ch] = 1'b0;
	endtask

	// mode 1 corrupts the last word of the first packet, mode 2 flags rx error
	// on the external path each word also carries its own error code
	task automatic inject_rx(input int ch, input int count, input int len, input int mode);
		int eff_len;
		int p;
		int w;
		logic [DATA_W-1:0] word;
		logic [EMPTY_W-1:0] empty;
		logic [RX_ERR_W-1:0] err;
		logic accepted;
		eff_len = (len == 0) ? 1 : len;
		for (p = 0; p < count; p++)
		begin
			for (w = 0; w < eff_len; w++)
			begin
				word = {32'(rx_next[ch] + p), 32'(w)};
				if (mode == 1 && p == 0 && w == eff_len - 1)
					word[DATA_W-1] = ~word[DATA_W-1];
				empty = (w == eff_len - 1) ? 3'd5 : 3'd0;
				if (mode == 2 && p == 0 && w == 0)
					err = 6'h01;
				else if (!path_local)
					err = RX_ERR_W'(w + 2);
				else
					err = '0;
				@(negedge clk);
				avl_st_rx_data[ch] = word;
				avl_st_rx_empty[ch] = empty;
				avl_st_rx_sop[ch] = (w == 0);
				avl_st_rx_eop[ch] = (w == eff_len - 1);
				avl_st_rx_error[ch] = err;
				avl_st_rx_val[ch] = 1'b1;
				accepted = 1'b0;
				// word is held until the receive side takes it
				while (!accepted)
				begin
					if (!path_local)
						ext_rx_ready[ch] = ($random(seed) % 4) != 0;
					#10;
					check_flag(avl_st_rx_ready[ch], path_local || ext_rx_ready[ch], "rx ready");
					if (path_local)
						check_flag(ext_rx_val[ch], 1'b0, "ext rx val on local path");
					else
					begin
						check_flag(ext_rx_val[ch], 1'b1, "ext rx val");
						check_word(ext_rx_data[ch], word, "ext rx data");
						check_word(DATA_W'(ext_rx_empty[ch]), DATA_W'(empty), "ext rx empty");
						check_word(DATA_W'(ext_rx_error[ch]), DATA_W'(err), "ext rx error");
						check_flag(ext_rx_sop[ch], w == 0, "ext rx sop");
						check_flag(ext_rx_eop[ch], w == eff_len - 1, "ext rx eop");
					end
					accepted = avl_st_rx_ready[ch];
					if (!accepted)
						@(negedge clk);
				end
			end
		end
		@(negedge clk);
		avl_st_rx_val[ch] = 1'b0;
		avl_st_rx_sop[ch] = 1'b0;
		avl_st_rx_eop[ch] = 1'b0;
		avl_st_rx_empty[ch] = '0;
		avl_st_rx_error[ch] = '0;
		ext_rx_ready[ch] = 1'b1;
		if (path_local)
		begin
			rx_next[ch] += count;
			if (mode == 1)
				mism_model[ch]++;
		end
		check_flag(mon_error[ch], mism_model[ch] != 0, "mon_error");
	endtask

	//////////////////////////////////////////////////////////////////////
	// pattern file

	task automatic count_words(input int fd, output int words);
		string line;
		logic [7:0] cmd;
		logic [63:0] a1;
		logic [63:0] a2;
		logic [63:0] a3;
		logic [63:0] a4;
		int n;
		words = 0;
		while (!$feof(fd))
		begin
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#")
			begin
				a3 = 0;
				n = $sscanf(line, "%c %h %h %h %h", cmd, a1, a2, a3, a4);
				if (cmd == "X" || cmd == "T")
					words += a2[31:0] * ((a3 == 0) ? 1 : a3[31:0]);
				else if (cmd == "E")
					words += 1;
			end
		end
	endtask

	task automatic run_patterns(input int fd);
		string line;
		logic [7:0] cmd;
		logic [63:0] a1;
		logic [63:0] a2;
		logic [63:0] a3;
		logic [63:0] a4;
		int n;
		int ch;
		while (!$feof(fd))
		begin
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#")
			begin
				n = $sscanf(line, "%c %h %h %h %h", cmd, a1, a2, a3, a4);
				case (cmd)
					"W":
					begin
						bus_write(a1[MM_ADDR_W-1:0], a2[MM_DATA_W-1:0]);
						if (a1[13:12] == REGION_SELECT)
							path_local = (a2[0] == SEL_LOCAL);
						else if (a1[13] && a1[2:0] == REG_CLEAR)
						begin
							ch = a1[12];
							rx_next[ch] = 0;
							mism_model[ch] = 0;
							check_flag(mon_error[ch], 1'b0, "mon_error after clear");
						end
					end
					"R": bus_read(a1[MM_ADDR_W-1:0], a2[MM_DATA_W-1:0]);
					"X": inject_rx(a1[0], a2[31:0], a3[31:0], a4[31:0]);
					"E": send_ext_tx(a1[0], a2);
					"T": expect_tx(a1[0], a2[31:0], a3[31:0]);
					default:
					begin
						other_errs++;
						$display("unknown command in pattern line: %s", line);
					end
				endcase
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		rst = 1'b1;
		avl_mm_read = 1'b0;
		avl_mm_write = 1'b0;
		avl_mm_baddress = '0;
		avl_mm_writedata = '0;
		avl_st_tx_ready = '0;
		avl_st_rx_data = '0;
		avl_st_rx_empty = '0;
		avl_st_rx_sop = '0;
		avl_st_rx_eop = '0;
		avl_st_rx_error = '0;
		avl_st_rx_val = '0;
		ext_tx_data = '0;
		ext_tx_empty = '0;
		ext_tx_sop = '0;
		ext_tx_eop = '0;
		ext_tx_error = '0;
		ext_tx_val = '0;
		ext_rx_ready = '1;
		path_local = 1'b1;
		rx_next = '{0, 0};
		mism_model = '{0, 0};
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_flag(|avl_st_tx_val, 1'b0, "tx val after reset");
		check_flag(|ext_rx_val, 1'b0, "ext rx val after reset");
		check_flag(|mon_error, 1'b0, "mon_error after reset");

		pat_fd = $fopen("testbench/traffic_patterns.txt", "r");
		if (pat_fd == 0)
		begin
			other_errs++;
			$display("could not open the pattern file testbench/traffic_patterns.txt");
		end
		else
		begin
			count_words(pat_fd, pat_words);
			$fclose(pat_fd);
			watch_cycles = pat_words * 4 + 200;
			pat_fd = $fopen("testbench/traffic_patterns.txt", "r");
			run_patterns(pat_fd);
			$fclose(pat_fd);
		end

		$display("%0d mismatches, %0d other errors", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clk);
		$display("timeout after %0d cycles, a packet or transfer never completed", watch_cycles);
		$display("%0d mismatches, %0d other errors", mismatch_errs, other_errs + 1);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* testbench/traffic_patterns.txt */
# all fields hex: W addr data | R addr expect | E ch word
# X ch count len mode (0 clean, 1 corrupt word, 2 rx error) | T ch count len
R 1000 00000001
R 0000 00000000
R 0005 00000000
R 2002 00000000
R 2003 00000000
R 2004 00000000
R 2005 00000000
R 3002 00000000
R 3003 00000000
R 3005 00000000
W 2000 00030401
T 0 3 4
R 2001 00000000
R 2002 00000003
X 0 2 3 0
R 2003 00000002
X 0 1 2 1
R 2003 00000003
R 2005 00000001
X 0 1 2 2
R 2004 00000001
R 2003 00000004
W 2006 00000000
R 2002 00000000
R 2003 00000000
R 2004 00000000
R 2005 00000000
W 1000 00000000
R 1000 00000000
E 0 0123456789abcdef
E 1 fedcba9876543210
X 0 2 3 0
R 2003 00000000
R 2005 00000000
W 1000 00000001
R 1000 00000001
W 2000 00020301
W 3000 00040201
T 0 2 3
T 1 4 2
R 2002 00000002
R 3002 00000004
R 2001 00000000
R 3001 00000000
X 1 2 2 0
R 3003 00000002
R 2003 00000000

/* filelist.f */
hdl/traffic_pkg.sv
hdl/mm_address_decoder.sv
hdl/stream_select_csr.sv
hdl/stream_path_mux.sv
hdl/channel_csr.sv
hdl/packet_generator.sv
hdl/packet_monitor.sv
hdl/traffic_controller_top.sv
testbench/traffic_controller_tb.sv

/* Bender.yml */
package:
  name: traffic_controller

sources:
  - hdl/traffic_pkg.sv
  - hdl/mm_address_decoder.sv
  - hdl/stream_select_csr.sv
  - hdl/stream_path_mux.sv
  - hdl/channel_csr.sv
  - hdl/packet_generator.sv
  - hdl/packet_monitor.sv
  - hdl/traffic_controller_top.sv
  - target: simulation
    files:
      - testbench/traffic_controller_tb.sv
